// File: Makefile
VERILATOR  ?= verilator
TOP        := sniffer_tb
FILELIST   := project.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: include/sniffer_settings.svh
`ifndef SNIFFER_SETTINGS_SVH
`define SNIFFER_SETTINGS_SVH

`define SNF_BYTE_W      8       // UART, register and USB byte
`define SNF_OP_W        16      // Operation word from the stack
`define SNF_ADDR_W      6       // PHY register address
`define SNF_LEN_W       10      // Packet length
`define SNF_RXCMD_W     6       // Last RxCMD seen
`define SNF_INFO_W      16      // RxCMD on top, length in the low bits

// Operation word layout
`define SNF_OP_CODE_HI  15
`define SNF_OP_CODE_LO  14
`define SNF_OP_ADDR_HI  13
`define SNF_OP_ADDR_LO  8
`define SNF_OP_VAL_HI   7
`define SNF_OP_VAL_LO   0

`define SNF_TOGGLE_KEY  8'h96   // Low byte that flips capture

`endif

// File: project.f
+incdir+include
rtl/cmd_pkg.sv
rtl/fsm_pkg.sv
rtl/op_sequencer.sv
rtl/ulpi_reg_port.sv
rtl/capture_forwarder.sv
rtl/sniffer_ctrl_top.sv
testbench/sniffer_tb.sv

// File: rtl/capture_forwarder.sv
`timescale 1ns/100ps
`include "sniffer_settings.svh"

module capture_forwarder
    import fsm_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fwd_start,
    input  logic [`SNF_INFO_W-1:0] ulpi_usb_info_data,
    input  logic [`SNF_BYTE_W-1:0] ulpi_usb_data,
    input  logic                   ulpi_data_buff_empty,
    input  logic                   uart_tx_full,
    input  logic [`SNF_BYTE_W-1:0] single_byte,
    input  logic                   single_send,
    output logic                   ulpi_info_re,
    output logic                   ulpi_data_re,
    output logic [`SNF_BYTE_W-1:0] uart_tx_data,
    output logic                   uart_send,
    output logic                   fwd_done
);

    fwd_state_t              state;
    logic                    hdr_cnt;   // Second header byte pending
    logic [`SNF_RXCMD_W-1:0] rxcmd;     // RxCMD of the current packet
    logic [`SNF_LEN_W-1:0]   len;       // Data bytes still to send
    logic                    accept;
    logic                    last_byte;

    assign ulpi_info_re = fwd_start;    // Header popped in the dispatch cycle
    assign accept       = uart_send && !uart_tx_full;
    assign last_byte    = (len == `SNF_LEN_W'(1));
    assign ulpi_data_re = (state == FWD_DATA) && accept;

    // UART port mux with single bytes passed through when not forwarding
    always_comb begin
        case (state)
            FWD_HEADER: begin
                uart_send    = 1'b1;
                uart_tx_data = hdr_cnt ? len[`SNF_BYTE_W-1:0]
                                       : {rxcmd, len[`SNF_LEN_W-1:`SNF_BYTE_W]};
            end
            FWD_DATA: begin
                uart_send    = !ulpi_data_buff_empty;   // Wait for the payload
                uart_tx_data = ulpi_usb_data;           // Show-ahead head
            end
            default: begin
                uart_send    = single_send;
                uart_tx_data = single_byte;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= FWD_IDLE;
            hdr_cnt  <= 1'b0;
            fwd_done <= 1'b0;
        end else begin
            fwd_done <= 1'b0;
            case (state)
                FWD_IDLE: begin
                    if (fwd_start) begin
                        state   <= FWD_HEADER;
                        hdr_cnt <= 1'b0;
                    end
                end
                FWD_HEADER: begin
                    if (accept) begin
                        hdr_cnt <= 1'b1;
                        if (hdr_cnt) begin
                            if (len == '0) begin
                                state    <= FWD_IDLE;   // Empty packet sends the header only
                                fwd_done <= 1'b1;
                            end else begin
                                state <= FWD_DATA;
                            end
                        end
                    end
                end
                FWD_DATA: begin
                    if (accept && last_byte) begin
                        state    <= FWD_IDLE;
                        fwd_done <= 1'b1;
                    end
                end
                default: state <= FWD_IDLE;
            endcase
        end
    end

    // Header fields at dispatch and a countdown per data byte
    always_ff @(posedge clk) begin
        if (fwd_start) begin
            rxcmd <= ulpi_usb_info_data[`SNF_INFO_W-1 -: `SNF_RXCMD_W];
            len   <= ulpi_usb_info_data[`SNF_LEN_W-1:0];
        end else if (ulpi_data_re) begin
            len <= len - `SNF_LEN_W'(1);
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        ulpi_data_re |-> !ulpi_data_buff_empty)
        else $error("ulpi_data_re high on an empty data buffer");

    // Sequencer never starts a packet or a single byte while one is streaming
    assert property (@(posedge clk) disable iff (!rst)
        fwd_start |-> state == FWD_IDLE)
        else $error("fwd_start while a packet is in progress");

    assert property (@(posedge clk) disable iff (!rst)
        state != FWD_IDLE |-> !single_send)
        else $error("single_send raised during a packet");

endmodule

// File: rtl/cmd_pkg.sv
package cmd_pkg;

    // Opcode carried in the top two bits of an operation word
    typedef enum logic [1:0] {
        OP_RECV_TOGGLE = 2'd0,  // Flip capture forwarding, keyed
        OP_REG_SEND    = 2'd1,  // Send last read register value
        OP_REG_WRITE   = 2'd2,  // PHY register write
        OP_REG_READ    = 2'd3   // PHY register read
    } op_code_t;

endpackage

// File: rtl/fsm_pkg.sv
package fsm_pkg;

    // Main dispatch FSM
    typedef enum logic [2:0] {
        SEQ_IDLE      = 3'd0,   // Waiting for a source
        SEQ_DISPATCH  = 3'd1,   // Chosen source acted on
        SEQ_REG_WAIT  = 3'd2,   // PHY register access in flight
        SEQ_UART_WAIT = 3'd3,   // Single byte waiting for the UART
        SEQ_FORWARD   = 3'd4    // Packet streamed by the forwarder
    } seq_state_t;

    // Packet forwarder
    typedef enum logic [1:0] {
        FWD_IDLE   = 2'd0,      // UART port lent to single bytes
        FWD_HEADER = 2'd1,      // Two header bytes
        FWD_DATA   = 2'd2       // Payload bytes from the data buffer
    } fwd_state_t;

endpackage

// File: rtl/op_sequencer.sv
`timescale 1ns/100ps
`include "sniffer_settings.svh"

module op_sequencer
    import cmd_pkg::*, fsm_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   force_send,
    input  logic [`SNF_OP_W-1:0]   op_stack_msg,
    input  logic                   op_stack_empty,
    input  logic                   ulpi_info_buff_empty,
    input  logic [`SNF_BYTE_W-1:0] ulpi_reg_val_r,
    input  logic                   uart_tx_full,
    input  logic                   reg_done,
    input  logic                   fwd_done,
    output logic                   op_stack_pull,
    output logic                   reg_start,
    output logic                   fwd_start,
    output logic [`SNF_BYTE_W-1:0] single_byte,
    output logic                   single_send,
    output logic                   toggle_status
);

    seq_state_t state;
    logic       from_stack;     // Dispatch serves the stack head
    logic       from_info;      // Dispatch serves a captured packet
    logic       capture_en;     // Packet forwarding on
    op_code_t   op_code;
    logic       in_dispatch;
    logic       info_ready;
    logic       key_match;
    logic       load_single;
    logic       single_accept;

    assign op_code       = op_code_t'(op_stack_msg[`SNF_OP_CODE_HI:`SNF_OP_CODE_LO]);
    assign in_dispatch   = (state == SEQ_DISPATCH);
    assign info_ready    = capture_en && !ulpi_info_buff_empty;
    assign key_match     = (op_stack_msg[`SNF_OP_VAL_HI:`SNF_OP_VAL_LO] == `SNF_TOGGLE_KEY);
    assign single_accept = single_send && !uart_tx_full;  // UART takes the byte

    // Register send from the stack, or force send
    assign load_single = in_dispatch && !from_info &&
                         (!from_stack || op_code == OP_REG_SEND);

    assign op_stack_pull = in_dispatch && from_stack;   // Head consumed this cycle
    assign reg_start     = in_dispatch && from_stack &&
                           (op_code == OP_REG_WRITE || op_code == OP_REG_READ);
    assign fwd_start     = in_dispatch && from_info;
    assign toggle_status = capture_en;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= SEQ_IDLE;
            from_stack <= 1'b0;
            from_info  <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    // Stack first, then capture, then force
                    from_stack <= !op_stack_empty;
                    from_info  <= op_stack_empty && info_ready;
                    if (!op_stack_empty || info_ready || force_send) begin
                        state <= SEQ_DISPATCH;
                    end
                end
                SEQ_DISPATCH: begin
                    if (from_info) begin
                        state <= SEQ_FORWARD;
                    end else if (!from_stack) begin
                        state <= SEQ_UART_WAIT;         // Force send
                    end else begin
                        case (op_code)
                            OP_RECV_TOGGLE: state <= SEQ_IDLE;
                            OP_REG_SEND:    state <= SEQ_UART_WAIT;
                            default:        state <= SEQ_REG_WAIT;
                        endcase
                    end
                end
                SEQ_REG_WAIT: begin
                    if (reg_done) begin
                        state <= SEQ_IDLE;
                    end
                end
                SEQ_UART_WAIT: begin
                    if (single_accept) begin
                        state <= SEQ_IDLE;
                    end
                end
                SEQ_FORWARD: begin
                    if (fwd_done) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Capture enable flipped only by the keyed toggle
    always_ff @(posedge clk) begin
        if (!rst) begin
            capture_en <= 1'b0;
        end else if (in_dispatch && from_stack && op_code == OP_RECV_TOGGLE && key_match) begin
            capture_en <= !capture_en;
        end
    end

    // Send level held until the UART accepts
    always_ff @(posedge clk) begin
        if (!rst) begin
            single_send <= 1'b0;
        end else if (load_single) begin
            single_send <= 1'b1;
        end else if (single_accept) begin
            single_send <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_single) begin
            single_byte <= ulpi_reg_val_r;  // Last PHY read value
        end
    end

    // A pull is only ever issued for a head that was present at selection
    assert property (@(posedge clk) disable iff (!rst)
        $rose(op_stack_pull) |-> !op_stack_empty)
        else $error("op_stack_pull raised while op_stack_empty is high");

endmodule

// File: rtl/sniffer_ctrl_top.sv
`timescale 1ns/100ps
`include "sniffer_settings.svh"

module sniffer_ctrl_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   force_send,
    input  logic [`SNF_OP_W-1:0]   op_stack_msg,
    input  logic                   op_stack_empty,
    input  logic                   ulpi_busy,
    input  logic [`SNF_BYTE_W-1:0] ulpi_usb_data,
    input  logic [`SNF_INFO_W-1:0] ulpi_usb_info_data,
    input  logic                   ulpi_data_buff_empty,
    input  logic                   ulpi_info_buff_empty,
    input  logic [`SNF_BYTE_W-1:0] ulpi_reg_val_r,
    input  logic                   uart_tx_full,
    output logic                   toggle_status,
    output logic                   op_stack_pull,
    output logic                   ulpi_data_re,
    output logic                   ulpi_info_re,
    output logic [`SNF_BYTE_W-1:0] ulpi_reg_val_w,
    output logic [`SNF_ADDR_W-1:0] ulpi_addr,
    output logic                   ulpi_prw,
    output logic                   ulpi_prr,
    output logic [`SNF_BYTE_W-1:0] uart_tx_data,
    output logic                   uart_send
);

    logic                   reg_start;      // Dispatch of a PHY access
    logic                   reg_done;
    logic                   fwd_start;      // Dispatch of a captured packet
    logic                   fwd_done;
    logic [`SNF_BYTE_W-1:0] single_byte;    // Register or forced byte
    logic                   single_send;

    op_sequencer u_op_sequencer (
        .clk                  (clk),
        .rst                  (rst),
        .force_send           (force_send),
        .op_stack_msg         (op_stack_msg),
        .op_stack_empty       (op_stack_empty),
        .ulpi_info_buff_empty (ulpi_info_buff_empty),
        .ulpi_reg_val_r       (ulpi_reg_val_r),
        .uart_tx_full         (uart_tx_full),
        .reg_done             (reg_done),
        .fwd_done             (fwd_done),
        .op_stack_pull        (op_stack_pull),
        .reg_start            (reg_start),
        .fwd_start            (fwd_start),
        .single_byte          (single_byte),
        .single_send          (single_send),
        .toggle_status        (toggle_status)
    );

    ulpi_reg_port u_ulpi_reg_port (
        .clk            (clk),
        .rst            (rst),
        .reg_start      (reg_start),
        .op_stack_msg   (op_stack_msg),
        .ulpi_busy      (ulpi_busy),
        .ulpi_addr      (ulpi_addr),
        .ulpi_reg_val_w (ulpi_reg_val_w),
        .ulpi_prw       (ulpi_prw),
        .ulpi_prr       (ulpi_prr),
        .reg_done       (reg_done)
    );

    capture_forwarder u_capture_forwarder (
        .clk                  (clk),
        .rst                  (rst),
        .fwd_start            (fwd_start),
        .ulpi_usb_info_data   (ulpi_usb_info_data),
        .ulpi_usb_data        (ulpi_usb_data),
        .ulpi_data_buff_empty (ulpi_data_buff_empty),
        .uart_tx_full         (uart_tx_full),
        .single_byte          (single_byte),
        .single_send          (single_send),
        .ulpi_info_re         (ulpi_info_re),
        .ulpi_data_re         (ulpi_data_re),
        .uart_tx_data         (uart_tx_data),
        .uart_send            (uart_send),
        .fwd_done             (fwd_done)
    );

endmodule

// File: rtl/ulpi_reg_port.sv
`timescale 1ns/100ps
`include "sniffer_settings.svh"

module ulpi_reg_port
    import cmd_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reg_start,
    input  logic [`SNF_OP_W-1:0]   op_stack_msg,
    input  logic                   ulpi_busy,
    output logic [`SNF_ADDR_W-1:0] ulpi_addr,
    output logic [`SNF_BYTE_W-1:0] ulpi_reg_val_w,
    output logic                   ulpi_prw,
    output logic                   ulpi_prr,
    output logic                   reg_done
);

    op_code_t op_code;

    assign op_code = op_code_t'(op_stack_msg[`SNF_OP_CODE_HI:`SNF_OP_CODE_LO]);

    // Last strobe cycle is the first one with the PHY controller idle
    assign reg_done = (ulpi_prw || ulpi_prr) && !ulpi_busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ulpi_prw <= 1'b0;
            ulpi_prr <= 1'b0;
        end else if (reg_start) begin
            ulpi_prw <= (op_code == OP_REG_WRITE);
            ulpi_prr <= (op_code == OP_REG_READ);
        end else if (reg_done) begin
            ulpi_prw <= 1'b0;
            ulpi_prr <= 1'b0;
        end
    end

    // Address for both directions, value only for writes
    always_ff @(posedge clk) begin
        if (reg_start) begin
            ulpi_addr <= op_stack_msg[`SNF_OP_ADDR_HI:`SNF_OP_ADDR_LO];
        end
        if (reg_start && op_code == OP_REG_WRITE) begin
            ulpi_reg_val_w <= op_stack_msg[`SNF_OP_VAL_HI:`SNF_OP_VAL_LO];
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        !(ulpi_prw && ulpi_prr))
        else $error("ulpi_prw and ulpi_prr high together");

    // Strobe and address stay put while the PHY controller is busy
    assert property (@(posedge clk) disable iff (!rst)
        (ulpi_prw || ulpi_prr) && ulpi_busy |=> $stable({ulpi_prw, ulpi_prr, ulpi_addr}))
        else $error("register access changed while ulpi_busy");

endmodule

// File: testbench/sniffer_input.txt
# Columns: OP word sync toggle n bytes | PKT rxcmd len data sync n bytes | FORCE n bytes
# All values hex; n counts the UART bytes the step adds to the expected stream
OP 853C 1 0 0
OP C500 1 0 0
OP 4000 1 0 1 3c
OP D200 1 0 0
OP 4000 1 0 1 ed
OP 0055 1 0 0
OP 0096 1 1 0
OP 0096 1 0 0
PKT 2a 3 11 22 33 0 0
OP 0055 1 0 0
OP 0096 1 1 5 a8 03 11 22 33
PKT 3f 0 1 2 fc 00
PKT 01 4 de ad be ef 1 6 04 04 de ad be ef
OP 8A77 0 1 0
PKT 15 2 aa bb 0 4 54 02 aa bb
FORCE 1 ed
OP CA00 1 1 0
OP 4000 1 1 1 77
FORCE 1 77
OP 0196 1 0 0

// File: testbench/sniffer_tb.sv
`timescale 1ns/100ps
`include "sniffer_settings.svh"

module sniffer_tb
    import cmd_pkg::*;
();

    logic                   clk;
    logic                   rst;
    logic                   force_send;
    logic [`SNF_OP_W-1:0]   op_stack_msg;
    logic                   op_stack_empty;
    logic                   ulpi_busy;
    logic [`SNF_BYTE_W-1:0] ulpi_usb_data;
    logic [`SNF_INFO_W-1:0] ulpi_usb_info_data;
    logic                   ulpi_data_buff_empty;
    logic                   ulpi_info_buff_empty;
    logic [`SNF_BYTE_W-1:0] ulpi_reg_val_r;
    logic                   uart_tx_full;
    logic                   toggle_status;
    logic                   op_stack_pull;
    logic                   ulpi_data_re;
    logic                   ulpi_info_re;
    logic [`SNF_BYTE_W-1:0] ulpi_reg_val_w;
    logic [`SNF_ADDR_W-1:0] ulpi_addr;
    logic                   ulpi_prw;
    logic                   ulpi_prr;
    logic [`SNF_BYTE_W-1:0] uart_tx_data;
    logic                   uart_send;

    logic [`SNF_OP_W-1:0]   op_q[$];        // Operation stack model
    logic [`SNF_INFO_W-1:0] info_q[$];      // Packet info buffer
    logic [`SNF_BYTE_W-1:0] data_q[$];      // Packet data buffer
    logic [`SNF_OP_W-1:0]   reg_q[$];       // Register ops still owed to the PHY
    logic [`SNF_BYTE_W-1:0] exp_q[$];       // Expected UART stream
    logic [`SNF_BYTE_W-1:0] phy_regs[64];
    logic [`SNF_OP_W-1:0]   exp_op;
    op_code_t               exp_code;
    logic                   rd_load;        // PrR completed and read value due
    logic [`SNF_BYTE_W-1:0] rd_val;
    logic                   force_req;
    logic                   stack_was_empty;    // Stack state the DUT saw at the last edge
    int                     rx_cnt;
    int                     cycles;
    int                     max_cycles;
    int                     busy_left;

    sniffer_ctrl_top dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;                  // 40 ns period

    task automatic fail_run(input string what);
        $display("%0t ns: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, sig, got, exp);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // DUT surroundings sampled at the edge and driven 2 ns later
    always @(posedge clk) begin
        cycles++;
        assert (cycles <= max_cycles) else fail_run("Run exceeded its cycle limit");
        rd_load = 1'b0;
        if (rst) begin
            if (op_stack_pull) begin
                assert (op_q.size() > 0) else fail_run("op_stack_pull on an empty stack");
                void'(op_q.pop_front());
            end
            if (ulpi_info_re) begin
                assert (toggle_status) else fail_run("Packet taken while capture is off");
                assert (stack_was_empty) else fail_run("Packet served ahead of a pending op");
                assert (info_q.size() > 0) else fail_run("ulpi_info_re on an empty buffer");
                void'(info_q.pop_front());
            end
            if (ulpi_data_re) begin
                assert (data_q.size() > 0) else fail_run("ulpi_data_re on an empty buffer");
                void'(data_q.pop_front());
            end
            if (ulpi_prw || ulpi_prr) begin
                assert (reg_q.size() > 0) else fail_run("Register strobe with no op queued");
                exp_op   = reg_q[0];
                exp_code = op_code_t'(exp_op[`SNF_OP_CODE_HI:`SNF_OP_CODE_LO]);
                assert (ulpi_prw == (exp_code == OP_REG_WRITE))
                    else report_mismatch("ulpi_prw", 16'(ulpi_prw),
                                         16'(exp_code == OP_REG_WRITE));
                assert (ulpi_prr == (exp_code == OP_REG_READ))
                    else report_mismatch("ulpi_prr", 16'(ulpi_prr),
                                         16'(exp_code == OP_REG_READ));
                assert (ulpi_addr == exp_op[`SNF_OP_ADDR_HI:`SNF_OP_ADDR_LO])
                    else report_mismatch("ulpi_addr", 16'(ulpi_addr),
                                         16'(exp_op[`SNF_OP_ADDR_HI:`SNF_OP_ADDR_LO]));
                if (ulpi_prw) begin
                    assert (ulpi_reg_val_w == exp_op[`SNF_OP_VAL_HI:`SNF_OP_VAL_LO])
                        else report_mismatch("ulpi_reg_val_w", 16'(ulpi_reg_val_w),
                                             16'(exp_op[`SNF_OP_VAL_HI:`SNF_OP_VAL_LO]));
                end
                if (!ulpi_busy) begin               // PHY takes the access now
                    if (ulpi_prw) begin
                        phy_regs[ulpi_addr] = ulpi_reg_val_w;
                    end else begin
                        rd_val  = phy_regs[ulpi_addr];
                        rd_load = 1'b1;
                    end
                    void'(reg_q.pop_front());
                end
            end
            if (uart_send && !uart_tx_full) begin   // Byte collector
                assert (rx_cnt < exp_q.size()) else fail_run("UART byte beyond the stream");
                assert (uart_tx_data == exp_q[rx_cnt])
                    else report_mismatch("uart_tx_data", 16'(uart_tx_data), 16'(exp_q[rx_cnt]));
                rx_cnt++;
            end
        end
        stack_was_empty = op_stack_empty;
        #2;
        if (rd_load) begin
            ulpi_reg_val_r = rd_val;
        end
        op_stack_empty       = (op_q.size() == 0);
        op_stack_msg         = op_stack_empty ? '0 : op_q[0];   // Show-ahead heads
        ulpi_info_buff_empty = (info_q.size() == 0);
        ulpi_usb_info_data   = ulpi_info_buff_empty ? '0 : info_q[0];
        ulpi_data_buff_empty = (data_q.size() == 0);
        ulpi_usb_data        = ulpi_data_buff_empty ? '0 : data_q[0];
        force_send           = force_req;
        uart_tx_full         = ($urandom % 4) == 0;             // Random stalls
        if (busy_left > 0) begin
            ulpi_busy = 1'b1;
            busy_left--;
        end else if ($urandom % 6 == 0) begin
            ulpi_busy = 1'b1;                               // Burst of 1 to 5 cycles
            busy_left = $urandom % 5;
        end else begin
            ulpi_busy = 1'b0;
        end
    end

    task automatic read_expected(input int fd, input int n);
        logic [`SNF_BYTE_W-1:0] b;
        for (int i = 0; i < n; i++) begin
            void'($fscanf(fd, "%h", b));
            exp_q.push_back(b);
        end
    endtask

    // Idle DUT, empty stack and the whole expected stream received
    task automatic wait_quiet();
        while (!(op_q.size() == 0 && reg_q.size() == 0 && rx_cnt == exp_q.size() &&
                 !ulpi_prw && !ulpi_prr && !uart_send)) begin
            @(posedge clk);
            #1;
        end
        repeat (6) @(posedge clk);          // Room for stray bytes
        #1;
    endtask

    initial begin
        int                     fd;
        int                     lines;
        int                     n;
        string                  kw;
        string                  line;
        logic [`SNF_OP_W-1:0]   word;
        logic                   sync;
        logic                   exp_tgl;
        logic [`SNF_RXCMD_W-1:0] rxcmd;
        logic [`SNF_LEN_W-1:0]  pkt_len;
        logic [`SNF_BYTE_W-1:0] b;
        void'($urandom(32'hfe692ea2));
        rst                  = 1'b0;
        force_send           = 1'b0;
        force_req            = 1'b0;
        op_stack_msg         = '0;
        op_stack_empty       = 1'b1;
        ulpi_busy            = 1'b0;
        ulpi_usb_data        = '0;
        ulpi_usb_info_data   = '0;
        ulpi_data_buff_empty = 1'b1;
        ulpi_info_buff_empty = 1'b1;
        ulpi_reg_val_r       = '0;
        uart_tx_full         = 1'b0;
        stack_was_empty      = 1'b1;
        rx_cnt               = 0;
        cycles               = 0;
        busy_left            = 0;
        lines                = 0;
        max_cycles           = 1000;
        for (int a = 0; a < 64; a++) begin
            phy_regs[a] = {a[5:0], 2'b00} ^ 8'ha5;  // Every address bit shows
        end
        fd = $fopen("testbench/sniffer_input.txt", "r");
        assert (fd != 0) else fail_run("Cannot open testbench/sniffer_input.txt");
        while ($fgets(line, fd) != 0) begin
            lines++;
        end
        $fclose(fd);
        max_cycles = 300 + 60 * lines;
        repeat (4) @(posedge clk);
        #2 rst = 1'b1;
        @(posedge clk);
        #1;
        fd = $fopen("testbench/sniffer_input.txt", "r");
        while ($fscanf(fd, "%s", kw) == 1) begin
            if (kw == "#") begin
                void'($fgets(line, fd));            // Column notes
            end else if (kw == "OP") begin
                void'($fscanf(fd, "%h %h %h %h", word, sync, exp_tgl, n));
                read_expected(fd, n);
                op_q.push_back(word);
                exp_code = op_code_t'(word[`SNF_OP_CODE_HI:`SNF_OP_CODE_LO]);
                if (exp_code == OP_REG_WRITE || exp_code == OP_REG_READ) begin
                    reg_q.push_back(word);
                end
                if (sync) begin
                    wait_quiet();
                    assert (toggle_status == exp_tgl)
                        else report_mismatch("toggle_status", 16'(toggle_status), 16'(exp_tgl));
                end
            end else if (kw == "PKT") begin
                void'($fscanf(fd, "%h %h", rxcmd, pkt_len));
                for (int i = 0; i < int'(pkt_len); i++) begin
                    void'($fscanf(fd, "%h", b));
                    data_q.push_back(b);
                end
                info_q.push_back({rxcmd, pkt_len});
                void'($fscanf(fd, "%h %h", sync, n));
                read_expected(fd, n);
                if (sync) begin
                    wait_quiet();
                end
            end else if (kw == "FORCE") begin
                void'($fscanf(fd, "%h", n));
                read_expected(fd, n);
                force_req = 1'b1;                   // Held until its byte is out
                while (rx_cnt != exp_q.size()) begin
                    @(posedge clk);
                    #1;
                end
                force_req = 1'b0;
                wait_quiet();
            end else begin
                fail_run($sformatf("Unknown keyword %s in the input file", kw));
            end
        end
        $fclose(fd);
        wait_quiet();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
